// File: design/div.sv
// Radix-2 restoring divider on magnitudes, one quotient bit per cycle.
// dividend_i, divisor_i, signed_i and rem_i must stay stable until hold_o falls.
// Divide by zero and signed overflow give the RISC-V M results.
`timescale 1ns/1ns
`default_nettype none
`include "muldiv_macros.svh"

module div (
    input  logic              clk,
    input  logic              reset_n,

    input  muldiv_pkg::word_t dividend_i,
    input  muldiv_pkg::word_t divisor_i,
    input  logic              signed_i,
    input  logic              rem_i,
    input  logic              enable_i,

    output logic              hold_o,
    output muldiv_pkg::word_t result_o
);

    localparam int W     = $bits(muldiv_pkg::word_t);
    localparam int STEPS = `MULDIV_DIV_STEPS;
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } div_state_e;

    div_state_e state;
    div_state_e state_next;

    logic [CNT_W-1:0]  step_cnt;
    logic              last_step;
    logic              load;

    logic              neg_dividend;
    logic              neg_divisor;
    muldiv_pkg::word_t abs_dividend;
    muldiv_pkg::word_t abs_divisor;

    muldiv_pkg::word_t quo_reg;
    muldiv_pkg::word_t rem_reg;
    muldiv_pkg::word_t dsr_reg;
    logic              neg_quo;
    logic              neg_rem;

    logic [W:0]        shifted;
    logic [W:0]        trial;

    // ----------------------------------------------------------
    // Operand conditioning
    // ----------------------------------------------------------

    assign neg_dividend = signed_i & dividend_i[W-1];
    assign neg_divisor  = signed_i & divisor_i[W-1];
    assign abs_dividend = neg_dividend ? -dividend_i : dividend_i;
    assign abs_divisor  = neg_divisor ? -divisor_i : divisor_i;

    assign load      = (state == IDLE) && enable_i;
    assign last_step = (step_cnt == CNT_W'(STEPS-1));

    // Partial remainder shifted one bit, then the trial subtract.
    assign shifted = {rem_reg, quo_reg[W-1]};
    assign trial   = shifted - {1'b0, dsr_reg};

    always_ff @(posedge clk) begin
        if (load) begin
            quo_reg <= abs_dividend;   // Dividend bits shift out as quotient bits shift in.
            rem_reg <= '0;
            dsr_reg <= abs_divisor;
            // A zero divisor keeps the all-ones quotient unsigned.
            neg_quo <= (neg_dividend ^ neg_divisor) & (divisor_i != '0);
            neg_rem <= neg_dividend;
        end else if (state == CALC) begin
            if (!trial[W]) begin
                rem_reg <= trial[W-1:0];
                quo_reg <= {quo_reg[W-2:0], 1'b1};
            end else begin
                rem_reg <= shifted[W-1:0];
                quo_reg <= {quo_reg[W-2:0], 1'b0};
            end
        end
    end

    // Sign correction, shown in DONE.
    assign result_o = rem_i ? (neg_rem ? -rem_reg : rem_reg)
                            : (neg_quo ? -quo_reg : quo_reg);

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------

    always_comb begin
        hold_o     = 1'b1;
        state_next = state;
        case (state)
            IDLE: begin
                hold_o     = enable_i;
                state_next = enable_i ? CALC : IDLE;
            end
            CALC: begin
                state_next = last_step ? DONE : CALC;
            end
            DONE: begin
                hold_o     = 1'b0;
                state_next = IDLE;
            end
            default: begin
                hold_o     = 1'b0;
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            state <= state_next;
            if (load) begin
                step_cnt <= '0;
            end else if (state == CALC) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mul.sv
// 32x32 multiplier built on one 17x17 signed MAC, one half-word product per cycle.
// Operands and signed_mode_i must stay stable while hold_o is high.
// result_o is meaningful only in the cycle hold_o falls.
`timescale 1ns/1ns
`default_nettype none
`include "muldiv_macros.svh"

module mul (
    input  logic                   clk,
    input  logic                   reset_n,

    input  muldiv_pkg::word_t      first_operand_i,
    input  muldiv_pkg::word_t      second_operand_i,
    input  muldiv_pkg::sign_mode_t signed_mode_i,
    input  logic                   enable_i,
    input  logic                   mul_low_i,

    output logic                   hold_o,
    output muldiv_pkg::word_t      result_o
);

    localparam int HW    = `MULDIV_HALF;
    localparam int ACC_W = `MULDIV_ACC_W;

    typedef enum logic [1:0] {
        ALBL,
        ALBH,
        AHBL,
        AHBH
    } mul_state_e;

    mul_state_e state;
    mul_state_e state_next;

    muldiv_pkg::half_t op_a;
    muldiv_pkg::half_t op_b;
    logic              sign_a;
    logic              sign_b;
    logic              high_signed;

    muldiv_pkg::acc_t  accum;
    muldiv_pkg::acc_t  mac_sum;
    muldiv_pkg::acc_t  mac_next;
    muldiv_pkg::acc_t  mac_reg;

    // ----------------------------------------------------------
    // MAC datapath
    // ----------------------------------------------------------

    assign high_signed = (signed_mode_i != 2'b00);

    // All terms signed, evaluated at accumulator width.
    assign mac_sum = $signed({sign_a, op_a}) * $signed({sign_b, op_b}) + $signed(accum);

    assign result_o = mac_next[2*HW-1:0];

    always_ff @(posedge clk) begin
        mac_reg <= mac_next;
    end

    // ----------------------------------------------------------
    // Step control
    // ----------------------------------------------------------

    always_comb begin
        op_a       = first_operand_i[HW-1:0];
        op_b       = second_operand_i[HW-1:0];
        sign_a     = 1'b0;
        sign_b     = 1'b0;
        accum      = '0;
        mac_next   = mac_sum;
        hold_o     = 1'b1;
        state_next = state;

        case (state)
            ALBL: begin
                // Unsigned low product, loaded every idle cycle.
                hold_o     = enable_i;
                state_next = enable_i ? ALBH : ALBL;
            end
            ALBH: begin
                op_b   = second_operand_i[2*HW-1:HW];
                sign_b = signed_mode_i[1] & second_operand_i[2*HW-1];
                accum  = {{(ACC_W-HW){1'b0}}, mac_reg[2*HW-1:HW]};
                if (mul_low_i) begin
                    // Keep bits 15:0 of ALBL under the low half of the sum.
                    mac_next = {{(ACC_W-2*HW){1'b0}}, mac_sum[HW-1:0], mac_reg[HW-1:0]};
                end
                state_next = AHBL;
            end
            AHBL: begin
                op_a   = first_operand_i[2*HW-1:HW];
                sign_a = signed_mode_i[0] & first_operand_i[2*HW-1];
                if (mul_low_i) begin
                    accum      = {{(ACC_W-HW){1'b0}}, mac_reg[2*HW-1:HW]};
                    mac_next   = {{(ACC_W-2*HW){1'b0}}, mac_sum[HW-1:0], mac_reg[HW-1:0]};
                    hold_o     = 1'b0;         // Low word done.
                    state_next = ALBL;
                end else begin
                    accum      = mac_reg;      // Both cross products at weight 2^16.
                    state_next = AHBH;
                end
            end
            AHBH: begin
                op_a   = first_operand_i[2*HW-1:HW];
                op_b   = second_operand_i[2*HW-1:HW];
                sign_a = signed_mode_i[0] & first_operand_i[2*HW-1];
                sign_b = signed_mode_i[1] & second_operand_i[2*HW-1];
                // Middle sum moved down to weight 2^32, sign kept for signed modes.
                accum      = {{(HW+1){high_signed & mac_reg[ACC_W-2]}},
                              mac_reg[ACC_W-2:HW]};
                hold_o     = 1'b0;
                state_next = ALBL;
            end
            default: begin
                hold_o     = 1'b0;
                state_next = ALBL;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ALBL;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: design/muldiv_macros.svh
// Fixed widths of the multiply/divide unit.
// The multiplier splits words in two 16-bit halves, so the word width is fixed.
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// Operand and result width.
`define MULDIV_XLEN 32

// Half-word slice fed to the 17x17 multiplier.
`define MULDIV_HALF 16

// 17x17 signed product plus carry room.
`define MULDIV_ACC_W 35

// One quotient bit per divider step.
`define MULDIV_DIV_STEPS 32

`endif

// File: design/muldiv_pkg.sv
// Shared types of the multiply/divide unit.
// Widths come from muldiv_macros.svh.
`default_nettype none
`include "muldiv_macros.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_XLEN-1:0]  word_t;       // Operand or result.
    typedef logic [`MULDIV_HALF-1:0]  half_t;       // Operand slice.
    typedef logic [`MULDIV_ACC_W-1:0] acc_t;        // MAC value.

    // Bit 0 marks the first operand signed, bit 1 the second.
    typedef logic [1:0] sign_mode_t;

    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

endpackage

`default_nettype wire

// File: design/muldiv_unit.sv
// M-extension execute unit for a 32-bit RISC-V core.
// enable_i is a level held with stable inputs until hold_o falls.
// result_o is valid in the cycle hold_o is low after a start.
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit (
    input  logic                   clk,
    input  logic                   reset_n,

    input  muldiv_pkg::muldiv_op_e operation_i,
    input  muldiv_pkg::word_t      first_operand_i,
    input  muldiv_pkg::word_t      second_operand_i,
    input  logic                   enable_i,

    output logic                   hold_o,
    output muldiv_pkg::word_t      result_o
);

    logic                   is_div;
    logic                   mul_low;
    muldiv_pkg::sign_mode_t mul_mode;
    logic                   div_signed;
    logic                   div_rem;

    logic                   mul_hold;
    logic                   div_hold;
    muldiv_pkg::word_t      mul_result;
    muldiv_pkg::word_t      div_result;

    // ----------------------------------------------------------
    // Operation decode
    // ----------------------------------------------------------

    always_comb begin
        is_div     = 1'b0;
        mul_low    = 1'b0;
        mul_mode   = 2'b00;
        div_signed = 1'b0;
        div_rem    = 1'b0;
        case (operation_i)
            muldiv_pkg::OP_MUL:    mul_low  = 1'b1;
            muldiv_pkg::OP_MULH:   mul_mode = 2'b11;
            muldiv_pkg::OP_MULHSU: mul_mode = 2'b01;  // rs1 signed, rs2 unsigned.
            muldiv_pkg::OP_MULHU:  mul_mode = 2'b00;
            muldiv_pkg::OP_DIV: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
            end
            muldiv_pkg::OP_DIVU: begin
                is_div = 1'b1;
            end
            muldiv_pkg::OP_REM: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
                div_rem    = 1'b1;
            end
            muldiv_pkg::OP_REMU: begin
                is_div  = 1'b1;
                div_rem = 1'b1;
            end
            default: is_div = 1'b0;
        endcase
    end

    mul u_mul (
        .clk              (clk),
        .reset_n          (reset_n),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .signed_mode_i    (mul_mode),
        .enable_i         (enable_i & ~is_div),
        .mul_low_i        (mul_low),
        .hold_o           (mul_hold),
        .result_o         (mul_result)
    );

    div u_div (
        .clk        (clk),
        .reset_n    (reset_n),
        .dividend_i (first_operand_i),
        .divisor_i  (second_operand_i),
        .signed_i   (div_signed),
        .rem_i      (div_rem),
        .enable_i   (enable_i & is_div),
        .hold_o     (div_hold),
        .result_o   (div_result)
    );

    // The unit that owns the operation drives the outputs.
    assign hold_o   = is_div ? div_hold : mul_hold;
    assign result_o = is_div ? div_result : mul_result;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the muldiv_unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module muldiv_tb \
    --Mdir obj_dir -o muldiv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/muldiv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: sources.f
+incdir+design
design/muldiv_pkg.sv
design/mul.sv
design/div.sv
design/muldiv_unit.sv
verif/muldiv_tb.sv

// File: verif/muldiv_tb.sv
// Self-checking testbench for muldiv_unit, driving inputs on the rising edge.
// Results and latency are checked on the falling edge of each completion cycle.
`timescale 1ns/1ns
`default_nettype none
`include "muldiv_macros.svh"

module muldiv_tb;

    localparam int XL          = `MULDIV_XLEN;
    localparam int N_RAND_MUL  = 200;
    localparam int N_RAND_DIV  = 50;
    localparam int N_MIXED     = 100;
    localparam int NUM_OPS     = 4 * (25 + N_RAND_MUL) + 4 * N_RAND_DIV + 16 + N_MIXED;
    localparam int CYCLE_LIMIT = NUM_OPS * 40 + 100;

    logic                   clk;
    logic                   reset_n;
    muldiv_pkg::muldiv_op_e operation_i;
    muldiv_pkg::word_t      first_operand_i;
    muldiv_pkg::word_t      second_operand_i;
    logic                   enable_i;
    logic                   hold_o;
    muldiv_pkg::word_t      result_o;

    integer            seed;
    int                error_count;
    int                ops_done;
    int                op_cycle;
    int                cycle_count;
    int                test_errors;
    int                test_ops;
    muldiv_pkg::word_t expected_result;
    muldiv_pkg::word_t dir_vals [5];

    muldiv_unit uut (
        .clk              (clk),
        .reset_n          (reset_n),
        .operation_i      (operation_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .enable_i         (enable_i),
        .hold_o           (hold_o),
        .result_o         (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Reference model and checker
    // ----------------------------------------------------------

    function automatic muldiv_pkg::word_t ref_muldiv(input muldiv_pkg::muldiv_op_e op,
                                                     input muldiv_pkg::word_t a,
                                                     input muldiv_pkg::word_t b);
        logic [2*XL-1:0] sa;
        logic [2*XL-1:0] sb;
        logic [2*XL-1:0] ua;
        logic [2*XL-1:0] ub;
        logic [2*XL-1:0] res;
        logic            ovf;
        sa  = {{XL{a[XL-1]}}, a};
        sb  = {{XL{b[XL-1]}}, b};
        ua  = {{XL{1'b0}}, a};
        ub  = {{XL{1'b0}}, b};
        ovf = (a == {1'b1, {(XL-1){1'b0}}}) && (b == {XL{1'b1}});
        case (op)
            muldiv_pkg::OP_MUL:    res = ua * ub;
            muldiv_pkg::OP_MULH:   res = (sa * sb) >> XL;
            muldiv_pkg::OP_MULHSU: res = (sa * ub) >> XL;
            muldiv_pkg::OP_MULHU:  res = (ua * ub) >> XL;
            muldiv_pkg::OP_DIV: begin
                if (b == '0) begin
                    res = {2*XL{1'b1}};
                end else if (ovf) begin
                    res = ua;
                end else begin
                    res = $signed(sa) / $signed(sb);   // Truncates toward zero.
                end
            end
            muldiv_pkg::OP_DIVU:   res = (b == '0) ? {2*XL{1'b1}} : ua / ub;
            muldiv_pkg::OP_REM: begin
                if (b == '0) begin
                    res = ua;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    res = $signed(sa) % $signed(sb);   // Sign of the dividend.
                end
            end
            default:               res = (b == '0) ? ua : ua % ub;
        endcase
        return res[XL-1:0];
    endfunction

    function automatic int done_cycle(input muldiv_pkg::muldiv_op_e op);
        case (op)
            muldiv_pkg::OP_MUL:    return 2;
            muldiv_pkg::OP_MULH,
            muldiv_pkg::OP_MULHSU,
            muldiv_pkg::OP_MULHU:  return 3;
            default:               return `MULDIV_DIV_STEPS + 1;
        endcase
    endfunction

    always @(negedge clk) begin
        if (!reset_n) begin
            op_cycle = 0;
        end else if (!enable_i) begin
            op_cycle = 0;
            if (hold_o) begin
                $display("ERROR at %0t: hold_o = 1, expected 0 while enable_i is low", $time);
                error_count++;
            end
        end else if (hold_o) begin
            op_cycle++;
        end else begin
            expected_result = ref_muldiv(operation_i, first_operand_i, second_operand_i);
            if (result_o !== expected_result) begin
                $display("ERROR at %0t: result_o = %h, expected %h (%s a=%h b=%h)", $time,
                         result_o, expected_result, operation_i.name(), first_operand_i,
                         second_operand_i);
                error_count++;
            end
            if (op_cycle != done_cycle(operation_i)) begin
                $display("ERROR at %0t: hold_o fell in cycle %0d, expected cycle %0d (%s)",
                         $time, op_cycle, done_cycle(operation_i), operation_i.name());
                error_count++;
            end
            ops_done++;
            op_cycle = 0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    // Called just after a rising edge; returns at the edge that ends the completion cycle.
    task automatic issue(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::word_t a,
                         input muldiv_pkg::word_t b);
        int target;
        target = ops_done + 1;
        operation_i      <= op;
        first_operand_i  <= a;
        second_operand_i <= b;
        enable_i         <= 1'b1;
        while (ops_done < target) @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        enable_i <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic report(input string name);
        $display("%-34s ops %4d  errors %0d", name, ops_done - test_ops,
                 error_count - test_errors);
        test_ops    = ops_done;
        test_errors = error_count;
    endtask

    task automatic run_op_set(input muldiv_pkg::muldiv_op_e op, input int n_rand,
                              input logic directed);
        muldiv_pkg::word_t a;
        muldiv_pkg::word_t b;
        muldiv_pkg::word_t sh;
        for (int i = 0; i < 5 && directed; i++) begin
            for (int j = 0; j < 5; j++) begin
                issue(op, dir_vals[i], dir_vals[j]);
                idle_cycles(1);
            end
        end
        repeat (n_rand) begin
            a  = $random(seed);
            b  = $random(seed);
            sh = $random(seed);
            if (op >= muldiv_pkg::OP_DIV) b = b >> sh[4:0];   // Spread the quotient sizes.
            issue(op, a, b);
            idle_cycles(1);
        end
    endtask

    initial begin
        muldiv_pkg::word_t a;
        muldiv_pkg::word_t b;
        muldiv_pkg::word_t r;
        seed             = 61;
        error_count      = 0;
        ops_done         = 0;
        op_cycle         = 0;
        cycle_count      = 0;
        test_errors      = 0;
        test_ops         = 0;
        dir_vals         = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        reset_n          = 1'b0;
        enable_i         = 1'b0;
        operation_i      = muldiv_pkg::OP_MUL;
        first_operand_i  = '0;
        second_operand_i = '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        idle_cycles(8);
        report("Test 1 idle after reset");
        run_op_set(muldiv_pkg::OP_MUL, N_RAND_MUL, 1'b1);
        report("Test 2 MUL");
        for (int k = 1; k < 4; k++) begin
            run_op_set(muldiv_pkg::muldiv_op_e'(3'(k)), N_RAND_MUL, 1'b1);
        end
        report("Test 3 MULH MULHSU MULHU");
        for (int k = 4; k < 8; k++) begin
            run_op_set(muldiv_pkg::muldiv_op_e'(3'(k)), N_RAND_DIV, 1'b0);
        end
        report("Test 4 DIV DIVU REM REMU");
        for (int k = 4; k < 8; k++) begin
            issue(muldiv_pkg::muldiv_op_e'(3'(k)), 32'h1234_5678, 32'h0);
            issue(muldiv_pkg::muldiv_op_e'(3'(k)), 32'h8000_0000, 32'h0);
            issue(muldiv_pkg::muldiv_op_e'(3'(k)), 32'hFFFF_FFFF, 32'h0);
            issue(muldiv_pkg::muldiv_op_e'(3'(k)), 32'h8000_0000, 32'hFFFF_FFFF);
            idle_cycles(1);
        end
        report("Test 5 divide by zero and overflow");
        repeat (N_MIXED) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            issue(muldiv_pkg::muldiv_op_e'(r[2:0]), a, b);
        end
        idle_cycles(2);
        report("Test 6 back to back mixed");

        $display("Summary: %0d operations checked, %0d errors", ops_done, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
